// ==== tileMemPkg.sv ====
// Shared widths, address fields, region codes and fabric transaction types for the tile memory
package tileMemPkg;

    // ============================================================
    // Basic types
    // ============================================================
    typedef logic [31:0] tWord;    // Data and address word
    typedef logic [3:0]  tByteEn;  // One bit per byte lane
    typedef logic [7:0]  tTileId;  // Tile id on the fabric

    // Fabric opcodes
    typedef enum logic [1:0] {
        Rd    = 2'd0,
        Wr    = 2'd1,
        RdRsp = 2'd2
    } tOpcode;

    // One fabric transaction, 74 bits
    typedef struct packed {
        tWord   address;
        tWord   data;
        tOpcode opcode;
        tTileId requestorId;
    } tTileTrans;

    // ============================================================
    // Address fields
    // ============================================================
    // Target tile id sits in the top byte
    localparam int TileIdMsb = 31;
    localparam int TileIdLsb = 24;

    // Region select inside a fabric address
    localparam int RegionMsb = 23;
    localparam int RegionLsb = 22;

    localparam logic [1:0] RegionImem = 2'd0;
    localparam logic [1:0] RegionDmem = 2'd1;

    // Who-am-I read, low 24 bits all ones with tile field zero
    localparam logic [23:0] WhoAmIOffset = 24'hFF_FFFF;

endpackage

// ==== memPortIf.sv ====
// Fabric-side port of a tile memory, driven by the fabric slave and served by a RAM
`timescale 1ns/10ps

interface memPortIf
    import tileMemPkg::*;
();

    logic wrEn;    // Full-word write this cycle
    tWord addr;    // Byte address, word index from bit 2
    tWord wrData;
    tWord rdData;  // Valid one cycle after addr

    modport host (output wrEn, addr, wrData, input rdData);
    modport ram  (input wrEn, addr, wrData, output rdData);

endinterface

// ==== dualPortRam.sv ====
// Word-addressed two-port RAM with byte enables and registered reads, used by both tile memories
`timescale 1ns/10ps

module dualPortRam
    import tileMemPkg::*;
#(
    parameter int AddrWidth = 10
) (
    input  logic                 Clock,
    // Port a
    input  logic [AddrWidth-1:0] addrA,
    input  tWord                 dataA,
    input  logic                 wrEnA,
    input  tByteEn               byteEnA,
    output tWord                 qA,
    // Port b
    input  logic [AddrWidth-1:0] addrB,
    input  tWord                 dataB,
    input  logic                 wrEnB,
    input  tByteEn               byteEnB,
    output tWord                 qB
);

    tWord mem [2**AddrWidth];

    always_ff @(posedge Clock) begin
        for (int i = 0; i < 4; i++) begin
            if (wrEnA && byteEnA[i]) begin
                mem[addrA][8*i +: 8] <= dataA[8*i +: 8];
            end
            if (wrEnB && byteEnB[i]) begin  // Port b wins a same-byte collision
                mem[addrB][8*i +: 8] <= dataB[8*i +: 8];
            end
        end
        qA <= mem[addrA];  // Old data on read-during-write
        qB <= mem[addrB];
    end

endmodule

// ==== transFifo.sv ====
// Small synchronous queue of fabric transactions; holds read responses or outbound core requests
`timescale 1ns/10ps

module transFifo
    import tileMemPkg::*;
#(
    parameter int Depth = 2
) (
    input  logic      Clock,
    input  logic      rst,
    input  logic      push,
    input  tTileTrans pushData,
    input  logic      pop,       // Only when the arbiter grants this queue
    output tTileTrans popData,
    output logic      full,
    output logic      almostFull,
    output logic      empty
);

    localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntWidth = $clog2(Depth + 1);

    tTileTrans           entries [Depth];  // Payload storage
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic [CntWidth-1:0] count;

    always_ff @(posedge Clock) begin
        if (push) begin
            entries[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;  // Wrap
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + CntWidth'(push) - CntWidth'(pop);
        end
    end

    assign popData    = entries[rdPtr];  // Head shows without a pop
    assign full       = (count == CntWidth'(Depth));
    assign almostFull = (count >= CntWidth'(Depth - 1));  // One slot or less left
    assign empty      = (count == '0);

    // Producer must respect full
    assert property (@(posedge Clock) disable iff (rst) full |-> !push);

endmodule

// ==== instrMemory.sv ====
// Instruction RAM for the core fetch path, written by the fabric, holds the output on fetch stall
`timescale 1ns/10ps

module instrMemory
    import tileMemPkg::*;
#(
    parameter int AddrWidth = 10
) (
    input  logic   Clock,
    input  logic   readyQ101H,
    input  tWord   pcQ100H,
    output tWord   preInstructionQ101H,
    memPortIf.ram  fabPort
);

    tWord instructionQ101H;      // Raw RAM output
    tWord lastInstructionQ101H;  // Last word shown to the core
    logic sampleReadyQ101H;

    dualPortRam #(
        .AddrWidth (AddrWidth)
    ) u_ram (
        .Clock   (Clock),
        .addrA   (pcQ100H[AddrWidth+1:2]),  // Fetch port reads only
        .dataA   ('0),
        .wrEnA   (1'b0),
        .byteEnA ('0),
        .qA      (instructionQ101H),
        .addrB   (fabPort.addr[AddrWidth+1:2]),
        .dataB   (fabPort.wrData),
        .wrEnB   (fabPort.wrEn),
        .byteEnB (4'b1111),                 // Fabric writes whole words
        .qB      (fabPort.rdData)
    );

    always_ff @(posedge Clock) begin
        sampleReadyQ101H <= readyQ101H;
        if (sampleReadyQ101H) begin
            lastInstructionQ101H <= instructionQ101H;  // Capture what was shown
        end
    end

    // Stalled fetch repeats the previous instruction
    assign preInstructionQ101H = sampleReadyQ101H ? instructionQ101H : lastInstructionQ101H;

endmodule

// ==== dataMemory.sv ====
// Data RAM of the core data port: byte alignment, local writes, who-am-I and response select
`timescale 1ns/10ps

module dataMemory
    import tileMemPkg::*;
#(
    parameter int AddrWidth = 10
) (
    input  logic   Clock,
    input  tTileId localTileId,
    // Core data port
    input  tWord   dMemWrDataQ103H,
    input  tWord   dMemAddressQ103H,
    input  tByteEn dMemByteEnQ103H,
    input  logic   dMemWrEnQ103H,
    input  logic   dMemRdEnQ103H,
    // Response of an older non-local read
    input  logic   fabRdValidQ504H,
    input  tWord   fabRdDataQ504H,
    output tWord   dMemRdRspQ104H,
    memPortIf.ram  fabPort
);

    tTileId    tileFieldQ103H;
    logic [1:0] offsetQ103H;
    logic [1:0] offsetQ104H;
    logic      localWrEnQ103H;
    tWord      shiftWrDataQ103H;
    tByteEn    shiftByteEnQ103H;
    tWord      ramRdDataQ104H;
    logic      whoAmIQ103H;
    logic      whoAmIQ104H;

    // ============================================================
    // Write side
    // ============================================================
    assign tileFieldQ103H = dMemAddressQ103H[TileIdMsb:TileIdLsb];
    assign offsetQ103H    = dMemAddressQ103H[1:0];

    // Own tile id or tile zero both mean local
    assign localWrEnQ103H = dMemWrEnQ103H &&
                            ((tileFieldQ103H == localTileId) || (tileFieldQ103H == '0));

    // Move data and enables up to the addressed byte lane
    assign shiftWrDataQ103H = dMemWrDataQ103H << {offsetQ103H, 3'b000};
    assign shiftByteEnQ103H = tByteEn'(dMemByteEnQ103H << offsetQ103H);

    assign whoAmIQ103H = dMemRdEnQ103H && (tileFieldQ103H == '0) &&
                         (dMemAddressQ103H[TileIdLsb-1:0] == WhoAmIOffset);

    dualPortRam #(
        .AddrWidth (AddrWidth)
    ) u_ram (
        .Clock   (Clock),
        .addrA   (dMemAddressQ103H[AddrWidth+1:2]),
        .dataA   (shiftWrDataQ103H),
        .wrEnA   (localWrEnQ103H),
        .byteEnA (shiftByteEnQ103H),
        .qA      (ramRdDataQ104H),
        .addrB   (fabPort.addr[AddrWidth+1:2]),
        .dataB   (fabPort.wrData),
        .wrEnB   (fabPort.wrEn),
        .byteEnB (4'b1111),
        .qB      (fabPort.rdData)
    );

    // ============================================================
    // Read side
    // ============================================================
    always_ff @(posedge Clock) begin
        offsetQ104H <= offsetQ103H;  // Aligns the read data next cycle
        whoAmIQ104H <= whoAmIQ103H;
    end

    // Fabric data first, then who-am-I, then the RAM shifted down with zero fill
    always_comb begin
        if (fabRdValidQ504H) begin
            dMemRdRspQ104H = fabRdDataQ504H;
        end else if (whoAmIQ104H) begin
            dMemRdRspQ104H = tWord'(localTileId);
        end else begin
            dMemRdRspQ104H = ramRdDataQ104H >> {offsetQ104H, 3'b000};
        end
    end

endmodule

// ==== fabricSlave.sv ====
// Inbound fabric decode: writes to either memory and read responses into the response queue
`timescale 1ns/10ps

module fabricSlave
    import tileMemPkg::*;
(
    input  logic      Clock,
    input  logic      rst,
    input  tTileId    localTileId,
    input  logic      inFabricValidQ503H,
    input  tTileTrans inFabricQ503H,
    memPortIf.host    imemPort,
    memPortIf.host    dmemPort,
    output logic      rspPush,
    output tTileTrans rspPushData
);

    logic [1:0] regionQ503H;
    logic       imemHitQ503H;
    logic       dmemHitQ503H;
    logic       wrReqQ503H;
    logic       rdReqQ503H;
    logic       rspValidQ504H;
    logic       imemHitQ504H;
    logic       dmemHitQ504H;
    tWord       rspAddressQ504H;

    assign regionQ503H  = inFabricQ503H.address[RegionMsb:RegionLsb];
    assign imemHitQ503H = (regionQ503H == RegionImem);
    assign dmemHitQ503H = (regionQ503H == RegionDmem);
    assign wrReqQ503H   = inFabricValidQ503H && (inFabricQ503H.opcode == Wr);
    assign rdReqQ503H   = inFabricValidQ503H && (inFabricQ503H.opcode == Rd);

    // Both RAMs see the address, only the hit one writes
    assign imemPort.wrEn   = wrReqQ503H && imemHitQ503H;
    assign imemPort.addr   = inFabricQ503H.address;
    assign imemPort.wrData = inFabricQ503H.data;
    assign dmemPort.wrEn   = wrReqQ503H && dmemHitQ503H;
    assign dmemPort.addr   = inFabricQ503H.address;
    assign dmemPort.wrData = inFabricQ503H.data;

    always_ff @(posedge Clock) begin
        if (rst) begin
            rspValidQ504H <= 1'b0;
        end else begin
            rspValidQ504H <= rdReqQ503H;
        end
    end

    always_ff @(posedge Clock) begin
        imemHitQ504H    <= imemHitQ503H;
        dmemHitQ504H    <= dmemHitQ503H;
        // Response goes back to the requester tile
        rspAddressQ504H <= {inFabricQ503H.requestorId, inFabricQ503H.address[TileIdLsb-1:0]};
    end

    assign rspPush = rspValidQ504H;

    always_comb begin
        rspPushData.address     = rspAddressQ504H;
        rspPushData.opcode      = RdRsp;
        rspPushData.requestorId = localTileId;  // We are the responder
        if (imemHitQ504H) begin
            rspPushData.data = imemPort.rdData;
        end else if (dmemHitQ504H) begin
            rspPushData.data = dmemPort.rdData;
        end else begin
            rspPushData.data = '0;  // Unmapped region
        end
    end

endmodule

// ==== coreFabricBridge.sv ====
// Bridge that the top level uses to send non-local core accesses to the fabric and track the pending read
`timescale 1ns/10ps

module coreFabricBridge
    import tileMemPkg::*;
(
    input  logic      Clock,
    input  logic      rst,
    input  tTileId    localTileId,
    input  tWord      dMemWrDataQ103H,
    input  tWord      dMemAddressQ103H,
    input  logic      dMemWrEnQ103H,
    input  logic      dMemRdEnQ103H,
    input  logic      inFabricValidQ503H,
    input  tTileTrans inFabricQ503H,
    output logic      reqPush,
    output tTileTrans reqPushData,
    input  logic      reqFull,
    output logic      fabRdValidQ504H,
    output tWord      fabRdDataQ504H,
    output logic      dMemReady
);

    tTileId tileFieldQ103H;
    logic   nonLocalQ103H;
    logic   outstandingRd;   // Non-local read in flight
    logic   rspMatchQ503H;

    assign tileFieldQ103H = dMemAddressQ103H[TileIdMsb:TileIdLsb];
    assign nonLocalQ103H  = (dMemWrEnQ103H || dMemRdEnQ103H) &&
                            (tileFieldQ103H != localTileId) && (tileFieldQ103H != '0);

    assign reqPush                 = nonLocalQ103H && !outstandingRd;
    assign reqPushData.address     = dMemAddressQ103H;
    assign reqPushData.data        = dMemWrDataQ103H;
    assign reqPushData.opcode      = dMemWrEnQ103H ? Wr : Rd;
    assign reqPushData.requestorId = localTileId;

    assign rspMatchQ503H = outstandingRd && inFabricValidQ503H && (inFabricQ503H.opcode == RdRsp);

    always_ff @(posedge Clock) begin
        if (rst) begin
            outstandingRd   <= 1'b0;
            fabRdValidQ504H <= 1'b0;
        end else begin
            if (rspMatchQ503H) begin
                outstandingRd <= 1'b0;
            end else if (reqPush && !dMemWrEnQ103H) begin
                outstandingRd <= 1'b1;  // Read went out
            end
            fabRdValidQ504H <= rspMatchQ503H;
        end
    end

    always_ff @(posedge Clock) begin
        fabRdDataQ504H <= inFabricQ503H.data;
    end

    // Stall the core on a pending read or a full queue
    assign dMemReady = !(outstandingRd || reqFull);

    // A non-local access during a pending read would be dropped
    assert property (@(posedge Clock) disable iff (rst) outstandingRd |-> !nonLocalQ103H);

endmodule

// ==== fabricArbiter.sv ====
// Round-robin choice between response and request queues toward the fabric output
`timescale 1ns/10ps

module fabricArbiter
    import tileMemPkg::*;
(
    input  logic      Clock,
    input  logic      rst,
    input  logic      fabReady,
    input  logic      rspEmpty,
    input  logic      reqEmpty,
    input  tTileTrans rspData,
    input  tTileTrans reqData,
    output logic      rspPop,
    output logic      reqPop,
    output logic      outFabricValidQ505H,
    output tTileTrans outFabricQ505H
);

    logic rspCand;
    logic reqCand;
    logic rspFirst;  // Round-robin priority that favors responses when high

    // No candidates while the fabric pushes back
    assign rspCand = !rspEmpty && fabReady;
    assign reqCand = !reqEmpty && fabReady;

    assign rspPop = rspCand && (rspFirst || !reqCand);
    assign reqPop = reqCand && !rspPop;

    always_ff @(posedge Clock) begin
        if (rst) begin
            rspFirst <= 1'b1;
        end else if (rspPop) begin
            rspFirst <= 1'b0;  // Requests next
        end else if (reqPop) begin
            rspFirst <= 1'b1;
        end
    end

    // ============================================================
    // Output mux
    // ============================================================
    assign outFabricValidQ505H = rspPop || reqPop;

    always_comb begin
        if (rspPop) begin
            outFabricQ505H = rspData;
        end else if (reqPop) begin
            outFabricQ505H = reqData;
        end else begin
            outFabricQ505H = '0;
        end
    end

    // With both queues waiting the next grant goes to the other queue
    assert property (@(posedge Clock) disable iff (rst)
        (rspPop && reqCand) |=> (reqPop || !fabReady));
    assert property (@(posedge Clock) disable iff (rst)
        (reqPop && rspCand) |=> (rspPop || !fabReady));

endmodule

// ==== accelMemWrap.sv ====
// Top of the tile memory wrapper: core fetch and data ports on one side, fabric on the other
`timescale 1ns/10ps

module accelMemWrap
    import tileMemPkg::*;
#(
    parameter int ImemAddrWidth = 10,
    parameter int DmemAddrWidth = 10,
    parameter int FifoDepth     = 2
) (
    input  logic      Clock,
    input  logic      rst,
    input  tTileId    localTileId,
    // Fetch port
    input  logic      readyQ101H,
    input  tWord      pcQ100H,
    output tWord      preInstructionQ101H,
    // Data port
    input  tWord      dMemWrDataQ103H,
    input  tWord      dMemAddressQ103H,
    input  tByteEn    dMemByteEnQ103H,
    input  logic      dMemWrEnQ103H,
    input  logic      dMemRdEnQ103H,
    output tWord      dMemRdRspQ104H,
    output logic      dMemReady,
    // Fabric in
    input  logic      inFabricValidQ503H,
    input  tTileTrans inFabricQ503H,
    output logic      miniCoreReady,
    // Fabric out
    output logic      outFabricValidQ505H,
    output tTileTrans outFabricQ505H,
    input  logic      fabReady
);

    logic      fabRdValidQ504H;
    tWord      fabRdDataQ504H;
    logic      rspPush, rspPop, rspEmpty, rspAlmostFull;
    tTileTrans rspPushData, rspPopData;
    logic      reqPush, reqPop, reqEmpty, reqFull;
    tTileTrans reqPushData, reqPopData;

    memPortIf imemPort ();
    memPortIf dmemPort ();

    // ============================================================
    // Memories
    // ============================================================
    instrMemory #(.AddrWidth(ImemAddrWidth)) u_instrMemory (
        .Clock, .readyQ101H, .pcQ100H, .preInstructionQ101H, .fabPort(imemPort.ram)
    );

    dataMemory #(.AddrWidth(DmemAddrWidth)) u_dataMemory (
        .Clock, .localTileId,
        .dMemWrDataQ103H, .dMemAddressQ103H, .dMemByteEnQ103H, .dMemWrEnQ103H, .dMemRdEnQ103H,
        .fabRdValidQ504H, .fabRdDataQ504H, .dMemRdRspQ104H, .fabPort(dmemPort.ram)
    );

    // ============================================================
    // Fabric paths and queues
    // ============================================================
    fabricSlave u_fabricSlave (
        .Clock, .rst, .localTileId, .inFabricValidQ503H, .inFabricQ503H,
        .imemPort(imemPort.host), .dmemPort(dmemPort.host), .rspPush, .rspPushData
    );

    coreFabricBridge u_coreFabricBridge (
        .Clock, .rst, .localTileId,
        .dMemWrDataQ103H, .dMemAddressQ103H, .dMemWrEnQ103H, .dMemRdEnQ103H,
        .inFabricValidQ503H, .inFabricQ503H, .reqPush, .reqPushData, .reqFull,
        .fabRdValidQ504H, .fabRdDataQ504H, .dMemReady
    );

    transFifo #(.Depth(FifoDepth)) u_rspFifo (
        .Clock, .rst, .push(rspPush), .pushData(rspPushData), .pop(rspPop),
        .popData(rspPopData), .full(), .almostFull(rspAlmostFull), .empty(rspEmpty)
    );

    transFifo #(.Depth(FifoDepth)) u_reqFifo (
        .Clock, .rst, .push(reqPush), .pushData(reqPushData), .pop(reqPop),
        .popData(reqPopData), .full(reqFull), .almostFull(), .empty(reqEmpty)
    );

    fabricArbiter u_fabricArbiter (
        .Clock, .rst, .fabReady, .rspEmpty, .reqEmpty,
        .rspData(rspPopData), .reqData(reqPopData), .rspPop, .reqPop,
        .outFabricValidQ505H, .outFabricQ505H
    );

    // Leaves one slot for a read already in the pipe
    assign miniCoreReady = !rspAlmostFull;

endmodule

// ==== tb_accelMemWrap.sv ====
// Directed testbench for the tile memory wrapper, compiled from build.f and run by run.sh
`timescale 1ns/10ps

module tb_accelMemWrap
    import tileMemPkg::*;
();

    localparam tTileId LocalId = 8'h05;  // Tile under test
    localparam int     Timeout = 50;     // Cycles allowed per wait

    logic      Clock;
    logic      rst;
    tTileId    localTileId;
    logic      readyQ101H;
    tWord      pcQ100H;
    tWord      preInstructionQ101H;
    tWord      dMemWrDataQ103H;
    tWord      dMemAddressQ103H;
    tByteEn    dMemByteEnQ103H;
    logic      dMemWrEnQ103H;
    logic      dMemRdEnQ103H;
    tWord      dMemRdRspQ104H;
    logic      dMemReady;
    logic      inFabricValidQ503H;
    tTileTrans inFabricQ503H;
    logic      miniCoreReady;
    logic      outFabricValidQ505H;
    tTileTrans outFabricQ505H;
    logic      fabReady;

    tWord      randState = 32'h352;
    tWord      imemModel [1024];   // Expected instruction words
    tWord      dmemModel [1024];   // Expected data words
    tTileTrans outQ [$];           // Everything seen leaving on the fabric
    int        checkCount = 0;
    int        errorCount = 0;
    int        timeoutCount = 0;

    accelMemWrap u_dut (.*);

    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;  // 4 ns period
    end

    // Outbound monitor, sampled mid-cycle
    always @(negedge Clock) begin
        if (!rst && outFabricValidQ505H) begin
            outQ.push_back(outFabricQ505H);
        end
    end

    // ============================================================
    // Helpers
    // ============================================================
    function tWord nextRandom();
        randState = randState ^ (randState << 13);  // xorshift32
        randState = randState ^ (randState >> 17);
        randState = randState ^ (randState << 5);
        return randState;
    endfunction

    function tWord coreAddr(input tTileId tile, input int idx, input logic [1:0] off);
        return {tile, 12'h000, 10'(idx), off};
    endfunction

    function tWord regionAddr(input tTileId tile, input logic [1:0] region, input int idx);
        return {tile, region, 10'h000, 10'(idx), 2'b00};
    endfunction

    function tTileTrans makeTrans(input tWord addr, input tWord data, input tOpcode op,
                                  input tTileId id);
        tTileTrans t;
        t.address     = addr;
        t.data        = data;
        t.opcode      = op;
        t.requestorId = id;
        return t;
    endfunction

    task automatic checkValue(input string name, input tWord got, input tWord exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error at %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic checkTrans(input string what, input tTileTrans got, input tTileTrans exp);
        checkValue({what, " address"}, got.address, exp.address);
        checkValue({what, " data"}, got.data, exp.data);
        checkValue({what, " opcode"}, tWord'(got.opcode), tWord'(exp.opcode));
        checkValue({what, " requestorId"}, tWord'(got.requestorId), tWord'(exp.requestorId));
    endtask

    // Waits at rising edges so the monitor push is never raced
    task automatic takeOutbound(output tTileTrans trans, output logic found);
        int waited;
        waited = 0;
        trans  = '0;
        do begin
            @(posedge Clock);
            waited++;
        end while (outQ.size() == 0 && waited < Timeout);
        found = (outQ.size() != 0);
        if (found) begin
            trans = outQ.pop_front();
        end else begin
            timeoutCount++;
            $display("timeout at %0t: no transaction left on the fabric", $time);
        end
    endtask

    task automatic waitMiniCoreReady(input logic level);
        int waited;
        waited = 0;
        do begin
            @(negedge Clock);
            waited++;
        end while (miniCoreReady !== level && waited < Timeout);
        if (miniCoreReady !== level) begin
            timeoutCount++;
            $display("timeout at %0t: miniCoreReady never went to %b", $time, level);
        end
    endtask

    task automatic sendInbound(input tTileTrans trans);
        @(posedge Clock);
        inFabricValidQ503H <= 1'b1;
        inFabricQ503H      <= trans;
    endtask

    task automatic idleInbound();
        @(posedge Clock);
        inFabricValidQ503H <= 1'b0;
    endtask

    // Local writes land in the model lane by lane, shifted by the byte offset
    task automatic coreWrite(input tWord addr, input tByteEn be, input tWord data);
        tWord   lanes;
        tByteEn laneEn;
        @(posedge Clock);
        dMemAddressQ103H <= addr;
        dMemByteEnQ103H  <= be;
        dMemWrDataQ103H  <= data;
        dMemWrEnQ103H    <= 1'b1;
        dMemRdEnQ103H    <= 1'b0;
        @(posedge Clock);
        dMemWrEnQ103H <= 1'b0;
        lanes  = data << (8 * addr[1:0]);
        laneEn = tByteEn'(be << addr[1:0]);
        if (addr[31:24] == localTileId || addr[31:24] == 8'h00) begin
            for (int i = 0; i < 4; i++) begin
                if (laneEn[i]) dmemModel[addr[11:2]][8*i +: 8] = lanes[8*i +: 8];
            end
        end
    endtask

    task automatic issueRead(input tWord addr);
        @(posedge Clock);
        dMemAddressQ103H <= addr;
        dMemRdEnQ103H    <= 1'b1;
        dMemWrEnQ103H    <= 1'b0;
        @(posedge Clock);
        dMemRdEnQ103H <= 1'b0;
    endtask

    task automatic readAndCheck(input tWord addr, input tWord exp);
        issueRead(addr);
        @(negedge Clock);  // Response of the cycle after the address
        checkValue("dMemRdRspQ104H", dMemRdRspQ104H, exp);
    endtask

    task automatic fetchAndCheck(input tWord pc, input tWord exp);
        @(posedge Clock);
        pcQ100H    <= pc;
        readyQ101H <= 1'b1;
        @(posedge Clock);
        @(negedge Clock);
        checkValue("preInstructionQ101H", preInstructionQ101H, exp);
    endtask

    // ============================================================
    // Tests
    // ============================================================
    task automatic imemFetchStall();
        tWord word;
        for (int i = 0; i < 4; i++) begin
            word = nextRandom();
            imemModel[i] = word;
            sendInbound(makeTrans(regionAddr(localTileId, RegionImem, i), word, Wr, 8'h11));
        end
        idleInbound();
        for (int i = 0; i < 4; i++) begin
            fetchAndCheck(coreAddr(8'h00, i, 2'd0), imemModel[i]);
        end
        // Stall on word 2, word 3 must stay on the output
        @(posedge Clock);
        pcQ100H    <= coreAddr(8'h00, 2, 2'd0);
        readyQ101H <= 1'b0;
        @(posedge Clock);
        @(negedge Clock);
        checkValue("preInstructionQ101H", preInstructionQ101H, imemModel[3]);
        @(negedge Clock);
        checkValue("preInstructionQ101H", preInstructionQ101H, imemModel[3]);
        fetchAndCheck(coreAddr(8'h00, 2, 2'd0), imemModel[2]);
    endtask

    task automatic localDataAccess();
        int idx;
        for (int off = 0; off < 4; off++) begin
            idx = 16 + off;
            coreWrite(coreAddr(localTileId, idx, 2'd0), 4'b1111, nextRandom());
            coreWrite(coreAddr(8'h00, idx, 2'(off)), 4'b0001, nextRandom());  // Byte
            readAndCheck(coreAddr(localTileId, idx, 2'd0), dmemModel[idx]);
            coreWrite(coreAddr(localTileId, idx, 2'(off)), 4'b0011, nextRandom());  // Half
            readAndCheck(coreAddr(8'h00, idx, 2'(off)), dmemModel[idx] >> (8 * off));
        end
        readAndCheck({8'h00, WhoAmIOffset}, tWord'(localTileId));
    endtask

    task automatic dmemRemoteRead();
        tWord      addr;
        tWord      data;
        tTileTrans got;
        logic      found;
        addr = regionAddr(localTileId, RegionDmem, 40);
        data = nextRandom();
        sendInbound(makeTrans(addr, data, Wr, 8'h3A));
        sendInbound(makeTrans(addr, 32'h0, Rd, 8'h3A));
        idleInbound();
        takeOutbound(got, found);
        if (found) begin
            checkTrans("read response", got,
                       makeTrans({8'h3A, addr[23:0]}, data, RdRsp, localTileId));
        end
    endtask

    task automatic nonLocalAccess();
        tWord      wrAddr;
        tWord      rdAddr;
        tWord      data;
        tWord      rspData;
        tTileTrans got;
        logic      found;
        wrAddr = {8'h22, 24'h000040};
        rdAddr = {8'h22, 24'h000080};
        data   = nextRandom();
        coreWrite(wrAddr, 4'b1111, data);
        takeOutbound(got, found);
        if (found) checkTrans("write request", got, makeTrans(wrAddr, data, Wr, localTileId));
        issueRead(rdAddr);
        @(negedge Clock);
        checkValue("dMemReady", tWord'(dMemReady), 32'd0);  // Blocked behind the read
        takeOutbound(got, found);
        if (found) checkTrans("read request", got, makeTrans(rdAddr, data, Rd, localTileId));
        rspData = nextRandom();
        sendInbound(makeTrans({localTileId, rdAddr[23:0]}, rspData, RdRsp, 8'h22));
        idleInbound();
        @(negedge Clock);
        checkValue("dMemRdRspQ104H", dMemRdRspQ104H, rspData);
        checkValue("dMemReady", tWord'(dMemReady), 32'd1);
    endtask

    task automatic backPressure();
        tWord      vals [3];
        tWord      addr;
        tTileTrans got;
        logic      found;
        for (int i = 0; i < 3; i++) begin
            vals[i] = nextRandom();
            sendInbound(makeTrans(regionAddr(localTileId, RegionDmem, 48 + i), vals[i], Wr,
                                  8'h10));
        end
        idleInbound();
        @(posedge Clock);
        fabReady <= 1'b0;
        sendInbound(makeTrans(regionAddr(localTileId, RegionDmem, 48), 32'h0, Rd, 8'h40));
        sendInbound(makeTrans(regionAddr(localTileId, RegionDmem, 49), 32'h0, Rd, 8'h41));
        idleInbound();
        waitMiniCoreReady(1'b0);
        repeat (6) begin
            @(negedge Clock);
            checkValue("outFabricValidQ505H", tWord'(outFabricValidQ505H), 32'd0);
        end
        // Third read enters as the fabric opens, queue drains as it fills
        sendInbound(makeTrans(regionAddr(localTileId, RegionDmem, 50), 32'h0, Rd, 8'h42));
        fabReady <= 1'b1;
        idleInbound();
        for (int i = 0; i < 3; i++) begin
            addr = regionAddr(8'h40 + 8'(i), RegionDmem, 48 + i);
            takeOutbound(got, found);
            if (found) checkTrans("queued response", got, makeTrans(addr, vals[i], RdRsp,
                                                                    localTileId));
        end
        waitMiniCoreReady(1'b1);
        checkValue("outbound queue size", tWord'(outQ.size()), 32'd0);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        rst                = 1'b1;
        localTileId        = LocalId;
        readyQ101H         = 1'b0;
        pcQ100H            = '0;
        dMemWrDataQ103H    = '0;
        dMemAddressQ103H   = '0;
        dMemByteEnQ103H    = '0;
        dMemWrEnQ103H      = 1'b0;
        dMemRdEnQ103H      = 1'b0;
        inFabricValidQ503H = 1'b0;
        inFabricQ503H      = '0;
        fabReady           = 1'b1;
        repeat (3) @(posedge Clock);
        rst <= 1'b0;
        @(negedge Clock);
        checkValue("outFabricValidQ505H", tWord'(outFabricValidQ505H), 32'd0);
        checkValue("dMemReady", tWord'(dMemReady), 32'd1);
        checkValue("miniCoreReady", tWord'(miniCoreReady), 32'd1);
        imemFetchStall();
        localDataAccess();
        dmemRemoteRead();
        nonLocalAccess();
        backPressure();
        repeat (2) @(posedge Clock);
        $display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
tileMemPkg.sv
memPortIf.sv
dualPortRam.sv
transFifo.sv
instrMemory.sv
dataMemory.sv
fabricSlave.sv
coreFabricBridge.sv
fabricArbiter.sv
accelMemWrap.sv
tb_accelMemWrap.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the tile memory wrapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_accelMemWrap -f build.f -o simv
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
    echo "No pass message found in $LOG"
    exit 1
fi
exit 0
